//--- filelist.f
+incdir+source
source/counter_bank_pkg.sv
source/chan_if.sv
source/event_edge_detect.sv
source/counter_channel.sv
source/count_readout.sv
source/counter_bank_top.sv
test/tb_counter_bank.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_counter_bank
FILELIST := filelist.f

BUILD    := obj_dir
LOG      := sim.log

.PHONY: simulate clean

# Build, run and look for the pass line in the log
simulate:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/tb_counter_bank.sv
// Counter bank testbench: clock, reset, stimulus, reference model and checking assertions

`timescale 1ns/1ps
`default_nettype none

`include "counter_bank_consts.svh"

module tb_counter_bank;

   localparam int TIMEOUT     = 60;
   localparam int RAND_CYCLES = 400;

   logic                          clk_i;
   logic                          rsn_i;
   counter_bank_pkg::chan_mask_t  evt_i;
   counter_bank_pkg::chan_mask_t  dir_i;
   counter_bank_pkg::chan_sel_t   sel_i;
   logic                          clr_wrap_i;
   counter_bank_pkg::cnt_t        cnt_o;
   counter_bank_pkg::chan_mask_t  wrap_o;

   // Reference model state
   counter_bank_pkg::chan_mask_t  m_prev;
   counter_bank_pkg::chan_mask_t  m_en;
   counter_bank_pkg::chan_mask_t  m_dn;
   counter_bank_pkg::chan_mask_t  m_wrap;
   counter_bank_pkg::chan_mask_t  m_flag;
   counter_bank_pkg::cnt_t        m_cnt [`CB_NUM_CHAN];
   counter_bank_pkg::cnt_t        exp_cnt;

   int                            cnt_err;
   int                            wrap_err;
   int                            timeout_cnt;
   int                            seed;
   logic [31:0]                   rnd;

   counter_bank_top u_dut (
      .clk_i      (clk_i),
      .rsn_i      (rsn_i),
      .evt_i      (evt_i),
      .dir_i      (dir_i),
      .sel_i      (sel_i),
      .clr_wrap_i (clr_wrap_i),
      .cnt_o      (cnt_o),
      .wrap_o     (wrap_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // Sample edge k, enable after k, count after k+1, flag after k+2
   always @(posedge clk_i or negedge rsn_i) begin
      if (!rsn_i) begin
         m_prev <= '0;
         m_en   <= '0;
         m_dn   <= '0;
         m_wrap <= '0;
         m_flag <= '0;
         for (int c = 0; c < `CB_NUM_CHAN; c++) begin
            m_cnt[c] <= `CB_RST_VAL;
         end
      end else begin
         m_prev <= evt_i;
         m_en   <= evt_i & ~m_prev;
         m_dn   <= dir_i;
         for (int c = 0; c < `CB_NUM_CHAN; c++) begin
            if (m_en[c] && m_dn[c]) begin
               m_cnt[c]  <= m_cnt[c] - 1'b1;
               m_wrap[c] <= (m_cnt[c] == '0);
            end else if (m_en[c]) begin
               m_cnt[c]  <= m_cnt[c] + 1'b1;
               m_wrap[c] <= (m_cnt[c] == {`CB_CNT_W{1'b1}});
            end else begin
               m_wrap[c] <= 1'b0;
            end
         end
         // A clear drops all flags, a new wrap still sets its flag
         if (clr_wrap_i) begin
            m_flag <= m_wrap;
         end else begin
            m_flag <= m_flag | m_wrap;
         end
      end
   end

   assign exp_cnt = m_cnt[sel_i];

   // --------------------------------------------------
   // Output checks
   // --------------------------------------------------

   a_cnt : assert property (@(posedge clk_i) disable iff (!rsn_i) cnt_o == exp_cnt)
      else begin
         cnt_err++;
         $display("Error: cnt_o (sel %0d) expected %h actual %h",
                  $sampled(sel_i), $sampled(exp_cnt), $sampled(cnt_o));
      end

   a_wrap : assert property (@(posedge clk_i) disable iff (!rsn_i) wrap_o == m_flag)
      else begin
         wrap_err++;
         $display("Error: wrap_o expected %h actual %h", $sampled(m_flag), $sampled(wrap_o));
      end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------

   // One cycle high, then low for one sampling edge
   task automatic pulse_event(input int ch, input logic dn);
      @(negedge clk_i);
      evt_i[ch] = 1'b1;
      dir_i[ch] = dn;
      @(negedge clk_i);
      evt_i[ch] = 1'b0;
   endtask

   task automatic drive_pulses(input int ch, input logic dn, input int n);
      for (int i = 0; i < n; i++) begin
         pulse_event(ch, dn);
      end
   endtask

   task automatic hold_event(input int ch, input int cycles);
      @(negedge clk_i);
      evt_i[ch] = 1'b1;
      dir_i[ch] = 1'b0;
      repeat (cycles) @(negedge clk_i);
      evt_i[ch] = 1'b0;
   endtask

   // Down pulse whose wrap lands on the same edge as a clear
   task automatic wrap_during_clear(input int ch);
      @(negedge clk_i);
      evt_i[ch] = 1'b1;
      dir_i[ch] = 1'b1;
      @(negedge clk_i);
      evt_i[ch] = 1'b0;
      @(negedge clk_i);
      clr_wrap_i = 1'b1;
      @(negedge clk_i);
      clr_wrap_i = 1'b0;
   endtask

   task automatic clear_flags();
      @(negedge clk_i);
      clr_wrap_i = 1'b1;
      @(negedge clk_i);
      clr_wrap_i = 1'b0;
   endtask

   task automatic wait_count(input counter_bank_pkg::chan_sel_t ch,
                             input counter_bank_pkg::cnt_t target);
      int n;
      @(negedge clk_i);
      sel_i = ch;
      @(negedge clk_i);
      n = 0;
      while (cnt_o !== target && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (cnt_o !== target) begin
         timeout_cnt++;
         $display("Timeout: channel %0d never reached count %h", ch, target);
      end
   endtask

   task automatic wait_flag(input int ch, input logic level);
      int n;
      n = 0;
      while (wrap_o[ch] !== level && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (wrap_o[ch] !== level) begin
         timeout_cnt++;
         $display("Timeout: wrap flag of channel %0d never became %0d", ch, level);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      cnt_err     = 0;
      wrap_err    = 0;
      timeout_cnt = 0;
      seed        = 32'h24118f0a;
      rsn_i       = 1'b0;
      evt_i       = '0;
      dir_i       = '0;
      sel_i       = '0;
      clr_wrap_i  = 1'b0;
      repeat (8) @(negedge clk_i);
      rsn_i = 1'b1;

      // Reset value on every channel
      for (int s = 0; s < `CB_NUM_CHAN; s++) begin
         wait_count(counter_bank_pkg::chan_sel_t'(s), `CB_RST_VAL);
      end

      // Up pulses, then a long level that counts once
      drive_pulses(1, 1'b0, 3);
      wait_count(2'd1, `CB_RST_VAL + 8'd3);
      hold_event(1, 12);
      wait_count(2'd1, `CB_RST_VAL + 8'd4);
      wait_count(2'd0, `CB_RST_VAL);
      wait_count(2'd2, `CB_RST_VAL);

      // Down below the reset value
      drive_pulses(2, 1'b1, 4);
      wait_count(2'd2, `CB_RST_VAL - 8'd4);

      // Up through 255, flag stays until cleared
      drive_pulses(0, 1'b0, 251);
      wait_count(2'd0, 8'h00);
      wait_flag(0, 1'b1);
      repeat (5) @(negedge clk_i);
      clear_flags();
      wait_flag(0, 1'b0);

      // Down through 0 on channel 3
      drive_pulses(3, 1'b1, 6);
      wait_count(2'd3, 8'hff);
      wait_flag(3, 1'b1);
      clear_flags();
      wait_flag(3, 1'b0);

      // Channel 2 goes 1 to 0, then wraps on the clear edge
      pulse_event(2, 1'b1);
      wait_count(2'd2, 8'h00);
      wrap_during_clear(2);
      wait_flag(2, 1'b1);
      wait_count(2'd2, 8'hff);
      clear_flags();

      // All channels at once from random vectors
      for (int i = 0; i < RAND_CYCLES; i++) begin
         @(negedge clk_i);
         rnd        = $random(seed);
         evt_i      = rnd[3:0];
         dir_i      = rnd[7:4];
         sel_i      = sel_i + 2'd1;
         clr_wrap_i = (rnd[12:8] == 5'h00);
      end
      @(negedge clk_i);
      evt_i      = '0;
      clr_wrap_i = 1'b0;
      for (int s = 0; s < 8; s++) begin
         @(negedge clk_i);
         sel_i = sel_i + 2'd1;
      end

      $display("Errors: cnt_o %0d, wrap_o %0d, timeouts %0d", cnt_err, wrap_err, timeout_cnt);
      if (cnt_err + wrap_err + timeout_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule : tb_counter_bank

`default_nettype wire

//--- source/counter_bank_top.sv
// Counter bank top level: edge detector, counter channels and readout

`timescale 1ns/1ps
`default_nettype none

`include "counter_bank_consts.svh"

module counter_bank_top (
   input  wire logic                          clk_i,
   input  wire logic                          rsn_i,

   // Event levels and per-channel direction
   input  wire counter_bank_pkg::chan_mask_t  evt_i,
   input  wire counter_bank_pkg::chan_mask_t  dir_i,

   // Readout control
   input  wire counter_bank_pkg::chan_sel_t   sel_i,
   input  wire logic                          clr_wrap_i,

   output      counter_bank_pkg::cnt_t        cnt_o,
   output      counter_bank_pkg::chan_mask_t  wrap_o
);

   // One interface per channel
   chan_if ch_if [`CB_NUM_CHAN] ();

   // --------------------------------------------------
   // Event edge detection
   // --------------------------------------------------

   event_edge_detect u_edge (
      .clk_i (clk_i),
      .rsn_i (rsn_i),
      .evt_i (evt_i),
      .dir_i (dir_i),
      .ctl_o (ch_if)
   );

   // --------------------------------------------------
   // Counter channels
   // --------------------------------------------------

   for (genvar g = 0; g < `CB_NUM_CHAN; g++) begin : g_chan
      counter_channel u_chan (
         .clk_i (clk_i),
         .rsn_i (rsn_i),
         .ch_io (ch_if[g])
      );
   end

   // --------------------------------------------------
   // Wrap flags and count select
   // --------------------------------------------------

   count_readout u_readout (
      .clk_i      (clk_i),
      .rsn_i      (rsn_i),
      .sel_i      (sel_i),
      .clr_wrap_i (clr_wrap_i),
      .mon_i      (ch_if),
      .cnt_o      (cnt_o),
      .wrap_o     (wrap_o)
   );

endmodule : counter_bank_top

`default_nettype wire

//--- source/count_readout.sv
// Count readout: sticky wrap flags and the count-select multiplexer

`timescale 1ns/1ps
`default_nettype none

`include "counter_bank_consts.svh"

module count_readout (
   input  wire logic                          clk_i,
   input  wire logic                          rsn_i,

   input  wire counter_bank_pkg::chan_sel_t   sel_i,
   input  wire logic                          clr_wrap_i,

   chan_if.mon                                mon_i [`CB_NUM_CHAN],

   output      counter_bank_pkg::cnt_t        cnt_o,
   output      counter_bank_pkg::chan_mask_t  wrap_o
);

   counter_bank_pkg::cnt_t        cnt_arr [`CB_NUM_CHAN];
   counter_bank_pkg::chan_mask_t  wrap_vec;
   counter_bank_pkg::chan_mask_t  flag_q;

   // Gather per-channel signals so they can be indexed by sel_i
   for (genvar g = 0; g < `CB_NUM_CHAN; g++) begin : g_mon
      assign cnt_arr[g]  = mon_i[g].cnt;
      assign wrap_vec[g] = mon_i[g].wrap;
   end

   // --------------------------------------------------
   // Sticky wrap flags
   // --------------------------------------------------

   // Set wins over a clear on the same edge
   always_ff @(posedge clk_i or negedge rsn_i) begin
      if (!rsn_i) begin
         flag_q <= '0;
      end else if (clr_wrap_i) begin
         flag_q <= wrap_vec;
      end else begin
         flag_q <= flag_q | wrap_vec;
      end
   end

   assign wrap_o = flag_q;

   // --------------------------------------------------
   // Count select
   // --------------------------------------------------

   assign cnt_o = cnt_arr[sel_i];

endmodule : count_readout

`default_nettype wire

//--- source/counter_channel.sv
// Up/down counter channel with reset value and registered wrap pulse

`timescale 1ns/1ps
`default_nettype none

`include "counter_bank_consts.svh"

module counter_channel (
   input  wire logic  clk_i,
   input  wire logic  rsn_i,

   chan_if.chan       ch_io
);

   localparam int W = `CB_CNT_W;

   counter_bank_pkg::cnt_t  cnt_q;
   logic                    wrap_q;

   counter_bank_pkg::cnt_t  step;
   counter_bank_pkg::cnt_t  step_neg;
   logic [W+1:0]            sum_ext;
   counter_bank_pkg::cnt_t  cnt_nxt;
   logic                    carry;

   // --------------------------------------------------
   // Add/subtract with carry out
   // --------------------------------------------------

   // Operand is the enable itself, so an idle cycle adds zero
   assign step = {{(W-1){1'b0}}, ch_io.cnt_en};

   // Invert operand for subtraction
   assign step_neg = step ^ {W{ch_io.cnt_dn}};

   // Extra low bit carries the direction in as carry-in
   assign sum_ext = {cnt_q, 1'b1} + {step_neg, ch_io.cnt_dn};

   assign cnt_nxt = sum_ext[W:1];
   assign carry   = sum_ext[W+1];

   // --------------------------------------------------
   // Count and wrap registers
   // --------------------------------------------------

   // Up wraps on carry, down wraps on missing carry (borrow)
   always_ff @(posedge clk_i or negedge rsn_i) begin
      if (!rsn_i) begin
         cnt_q  <= `CB_RST_VAL;
         wrap_q <= 1'b0;
      end else begin
         cnt_q  <= cnt_nxt;
         wrap_q <= carry ^ ch_io.cnt_dn;
      end
   end

   assign ch_io.cnt  = cnt_q;
   assign ch_io.wrap = wrap_q;

endmodule : counter_channel

`default_nettype wire

//--- source/event_edge_detect.sv
// Event edge detector: turns event levels into one-cycle count enables

`timescale 1ns/1ps
`default_nettype none

`include "counter_bank_consts.svh"

module event_edge_detect (
   input  wire logic                          clk_i,
   input  wire logic                          rsn_i,

   input  wire counter_bank_pkg::chan_mask_t  evt_i,
   input  wire counter_bank_pkg::chan_mask_t  dir_i,

   chan_if.ctrl                               ctl_o [`CB_NUM_CHAN]
);

   counter_bank_pkg::chan_mask_t evt_q;
   counter_bank_pkg::chan_mask_t rise;
   counter_bank_pkg::chan_mask_t en_q;
   counter_bank_pkg::chan_mask_t dn_q;

   // --------------------------------------------------
   // Previous event level
   // --------------------------------------------------

   always_ff @(posedge clk_i or negedge rsn_i) begin
      if (!rsn_i) begin
         evt_q <= '0;
      end else begin
         evt_q <= evt_i;
      end
   end

   // High now and low at the previous sample
   assign rise = evt_i & ~evt_q;

   // --------------------------------------------------
   // Registered enable and direction
   // --------------------------------------------------

   always_ff @(posedge clk_i or negedge rsn_i) begin
      if (!rsn_i) begin
         en_q <= '0;
         dn_q <= '0;
      end else begin
         en_q <= rise;
         dn_q <= dir_i;
      end
   end

   // Fan out to the channel interfaces
   for (genvar g = 0; g < `CB_NUM_CHAN; g++) begin : g_ctl
      assign ctl_o[g].cnt_en = en_q[g];
      assign ctl_o[g].cnt_dn = dn_q[g];
   end

endmodule : event_edge_detect

`default_nettype wire

//--- source/chan_if.sv
// Per-channel interface between edge detector, counter channel and readout

`timescale 1ns/1ps
`default_nettype none

interface chan_if;

   // Single-cycle count enable from the edge detector
   logic                    cnt_en;

   // Direction, 1 counts down and 0 counts up
   logic                    cnt_dn;

   // Registered count of this channel
   counter_bank_pkg::cnt_t  cnt;

   // High for one cycle after the count wrapped
   logic                    wrap;

   // Edge detector side
   modport ctrl (
      output cnt_en,
      output cnt_dn
   );

   // Counter side
   modport chan (
      input  cnt_en,
      input  cnt_dn,
      output cnt,
      output wrap
   );

   // Readout side
   modport mon (
      input  cnt,
      input  wrap
   );

endinterface : chan_if

`default_nettype wire

//--- source/counter_bank_pkg.sv
// Counter bank types: count value, per-channel mask and channel select

`default_nettype none

`include "counter_bank_consts.svh"

package counter_bank_pkg;

   // One counter value
   typedef logic [`CB_CNT_W-1:0] cnt_t;

   // One bit per channel
   // Used for event, direction and wrap vectors
   typedef logic [`CB_NUM_CHAN-1:0] chan_mask_t;

   // Channel index for the readout mux
   typedef logic [1:0] chan_sel_t;

endpackage : counter_bank_pkg

`default_nettype wire

//--- source/counter_bank_consts.svh
// Counter bank constants: channel count, counter width and reset value

`ifndef COUNTER_BANK_CONSTS_SVH
`define COUNTER_BANK_CONSTS_SVH

// --------------------------------------------------
// Bank geometry
// --------------------------------------------------

// Number of independent event channels
`define CB_NUM_CHAN 4

// Bits per counter, counts wrap modulo 2^CB_CNT_W
`define CB_CNT_W 8

// --------------------------------------------------
// Reset state
// --------------------------------------------------

// Value loaded into every counter while rsn_i is low
`define CB_RST_VAL 8'h05

`endif
